//--- synth.f
hw/synth_pkg.sv
hw/voice_ctrl_if.sv
hw/key_event_decoder.sv
hw/dds_voice_bank.sv
hw/voice_mixer.sv
hw/echo_pwm_out.sv
hw/synth_top.sv
verif/synth_tb.sv

//--- verif/synth_tb.sv
// Synth testbench
module synth_tb;
    localparam int num_voices  = 8;      // Matches DUT defaults
    localparam int delay_depth = 1024;
    localparam int frame_len   = 1024;   // PWM frame in cycles
    localparam int max_gap     = 3;      // Idle cycles between rows

    typedef struct {
        synth_pkg::key_code_t  code;
        int                    duty_max;    // Negative skips the audio check
        synth_pkg::octave_t    exp_oct;
        synth_pkg::pitch_t     exp_pitch;
        logic                  exp_echo;
        logic [num_voices-1:0] exp_voices;
    } row_t;

    logic clk;
    logic reset;
    synth_pkg::key_code_t  rx_data;
    logic                  rx_valid;
    logic                  audio_out;
    synth_pkg::octave_t    octave_shift;
    synth_pkg::pitch_t     pitch_mod;
    logic                  echo_on;
    logic [num_voices-1:0] voice_active;

    row_t table_q[$];

    // Reference decoder state
    logic                  m_break;
    int                    m_oct;
    int                    m_pitch;
    logic                  m_echo;
    synth_pkg::key_code_t  m_key [num_voices];
    logic [num_voices-1:0] m_active;

    synth_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .audio_out    (audio_out),
        .octave_shift (octave_shift),
        .pitch_mod    (pitch_mod),
        .echo_on      (echo_on),
        .voice_active (voice_active)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Reference model of the key decoder
    // ========================================================================
    task automatic model_step(input synth_pkg::key_code_t code);
        logic held;
        logic found;
        held = 1'b0;
        found = 1'b0;
        if (code == synth_pkg::break_prefix) begin
            m_break = 1'b1;
        end else if (m_break) begin
            m_break = 1'b0;
            for (int i = 0; i < num_voices; i++)
                if (m_active[i] && m_key[i] == code) m_active[i] = 1'b0;  // Release
        end else if (code == synth_pkg::key_oct_down) begin
            if (m_oct > synth_pkg::min_octave) m_oct--;
        end else if (code == synth_pkg::key_oct_up) begin
            if (m_oct < synth_pkg::max_octave) m_oct++;
        end else if (code == synth_pkg::key_pitch_down) begin
            if (m_pitch > -synth_pkg::max_pitch_mod) m_pitch -= synth_pkg::pitch_mod_step;
        end else if (code == synth_pkg::key_pitch_up) begin
            if (m_pitch < synth_pkg::max_pitch_mod) m_pitch += synth_pkg::pitch_mod_step;
        end else if (code == synth_pkg::key_echo) begin
            m_echo = ~m_echo;
        end else if (synth_pkg::note_freq(code) != '0) begin
            for (int i = 0; i < num_voices; i++)
                if (m_active[i] && m_key[i] == code) held = 1'b1;
            for (int i = 0; i < num_voices; i++) begin
                if (!held && !found && !m_active[i]) begin  // Lowest idle voice
                    found = 1'b1;
                    m_active[i] = 1'b1;
                    m_key[i] = code;
                end
            end
        end
    endtask

    // Appends reps rows of one code with the expected state from the model
    task automatic push_row(input synth_pkg::key_code_t code, input int reps, input int duty);
        row_t r;
        for (int n = 0; n < reps; n++) begin
            model_step(code);
            r.code       = code;
            r.duty_max   = duty;
            r.exp_oct    = synth_pkg::octave_t'(m_oct);
            r.exp_pitch  = synth_pkg::pitch_t'(m_pitch);
            r.exp_echo   = m_echo;
            r.exp_voices = m_active;
            table_q.push_back(r);
        end
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_octave(input string name, input synth_pkg::octave_t exp,
                                input synth_pkg::octave_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_pitch(input string name, input synth_pkg::pitch_t exp,
                               input synth_pkg::pitch_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_voices(input string name, input logic [num_voices-1:0] exp,
                                input logic [num_voices-1:0] act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_duty(input string name, input int bound, input int high);
        if (high > bound) begin
            $display("error at %0t: %s high cycles expected at most %0d actual %0d",
                     $time, name, bound, high);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // High cycles of audio_out over one full frame sampled mid cycle
    task automatic measure_duty(output int high);
        high = 0;
        repeat (frame_len) begin
            @(negedge clk);
            if (audio_out) high++;
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        longint limit;
        int     gap;
        int     high;
        rx_data  = '0;
        rx_valid = 1'b0;
        reset    = 1'b1;
        m_break  = 1'b0;
        m_oct    = 0;
        m_pitch  = 0;
        m_echo   = 1'b0;
        m_active = '0;
        void'($urandom(32'hd342_a393));

        push_row(8'h22, 5, -1);   // Octave up with the last press past the limit
        push_row(8'h1a, 7, -1);   // Down to -3 and one more
        push_row(8'h22, 3, -1);
        push_row(8'h32, 26, -1);  // Pitch up to +100 and one more
        push_row(8'h2a, 51, -1);  // Down to -100 and one more
        push_row(8'h32, 25, -1);
        push_row(8'h1c, 1, -1);   // Fill all eight voices
        push_row(8'h1d, 1, -1);
        push_row(8'h1b, 1, -1);
        push_row(8'h24, 1, -1);
        push_row(8'h23, 1, -1);
        push_row(8'h2b, 1, -1);
        push_row(8'h2c, 1, -1);
        push_row(8'h34, 1, -1);
        push_row(8'h1c, 1, -1);   // Already sounding
        push_row(8'h35, 1, -1);   // Bank full
        push_row(8'hf0, 1, -1);
        push_row(8'h1d, 1, -1);   // Frees voice 1
        push_row(8'h15, 1, -1);   // Not a note or control key
        push_row(8'h35, 1, -1);   // Takes voice 1
        push_row(8'hf0, 1, -1);
        push_row(8'h1b, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h24, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h23, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h2b, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h2c, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h34, 1, -1);
        push_row(8'hf0, 1, -1);
        push_row(8'h35, 1, 256);  // Single voice left with echo off
        push_row(8'h21, 1, 256);  // Echo on with one voice
        push_row(8'h21, 3, -1);   // Toggles back to off
        push_row(8'hf0, 1, -1);
        push_row(8'h1c, 1, 0);    // Silence once the last voice is gone
        push_row(8'h21, 1, 0);    // Echo on with the delay line already flushed

        // Watchdog sized from the table length
        limit = longint'(table_q.size()) * (max_gap + 2 * frame_len + delay_depth)
                + 10 + frame_len + 16;
        fork
            begin
                #(limit * 100);
                $display("Watchdog timeout: the run took longer than %0d cycles", limit);
                $display("Simulation failed");
                $fatal(1);
            end
        join_none

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Reset state
        @(negedge clk);
        check_octave("octave_shift", '0, octave_shift);
        check_pitch("pitch_mod", '0, pitch_mod);
        check_flag("echo_on", 1'b0, echo_on);
        check_voices("voice_active", '0, voice_active);
        measure_duty(high);
        check_duty("audio_out", 0, high);

        foreach (table_q[i]) begin
            @(posedge clk);
            rx_data  <= table_q[i].code;
            rx_valid <= 1'b1;
            @(posedge clk);                 // Byte taken at this edge
            rx_valid <= 1'b0;
            @(negedge clk);
            check_octave("octave_shift", table_q[i].exp_oct, octave_shift);
            check_pitch("pitch_mod", table_q[i].exp_pitch, pitch_mod);
            check_flag("echo_on", table_q[i].exp_echo, echo_on);
            check_voices("voice_active", table_q[i].exp_voices, voice_active);
            if (table_q[i].duty_max >= 0) begin
                repeat (delay_depth) @(negedge clk);  // Let the delay line refill
                measure_duty(high);
                check_duty("audio_out", table_q[i].duty_max, high);
            end
            gap = $urandom_range(0, max_gap);
            repeat (gap) @(posedge clk);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- hw/synth_top.sv
// Polyphonic sine synthesizer top
module synth_top #(
    parameter int num_voices  = 8,
    parameter int delay_depth = 1024
) (
    input  logic                  clk,
    input  logic                  reset,
    input  synth_pkg::key_code_t  rx_data,
    input  logic                  rx_valid,
    output logic                  audio_out,
    output synth_pkg::octave_t    octave_shift,   // Status for LEDs
    output synth_pkg::pitch_t     pitch_mod,
    output logic                  echo_on,
    output logic [num_voices-1:0] voice_active
);
    voice_ctrl_if #(.num_voices(num_voices)) vc_if ();

    logic [num_voices-1:0][synth_pkg::lut_addr_bits-1:0] voice_addr;
    synth_pkg::sample_t mix_sample;

    key_event_decoder #(.num_voices(num_voices)) decoder_i (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .ctrl     (vc_if.ctrl),
        .echo_on  (echo_on)
    );

    dds_voice_bank #(.num_voices(num_voices)) voice_bank_i (
        .clk        (clk),
        .reset      (reset),
        .voices     (vc_if.voices),
        .voice_addr (voice_addr)
    );

    voice_mixer #(.num_voices(num_voices)) mixer_i (
        .voices     (vc_if.voices),
        .voice_addr (voice_addr),
        .mix_sample (mix_sample)
    );

    echo_pwm_out #(.delay_depth(delay_depth)) out_i (
        .clk        (clk),
        .reset      (reset),
        .mix_sample (mix_sample),
        .echo_on    (echo_on),
        .audio_out  (audio_out)
    );

    // Decoder state straight out to the board
    assign octave_shift = vc_if.octave_shift;
    assign pitch_mod    = vc_if.pitch_mod;
    assign voice_active = vc_if.voice_active;

endmodule

//--- hw/echo_pwm_out.sv
// Echo and PWM output stage
module echo_pwm_out #(
    parameter int delay_depth = 1024   // Power of two
) (
    input  logic               clk,
    input  logic               reset,
    input  synth_pkg::sample_t mix_sample,
    input  logic               echo_on,
    output logic               audio_out
);
    localparam int ptr_bits = $clog2(delay_depth);

    synth_pkg::sample_t             delay_ram [delay_depth];
    logic [ptr_bits-1:0]            delay_ptr;       // Wraps at depth
    synth_pkg::sample_t             delayed_sample;
    logic [synth_pkg::pwm_bits:0]   echo_sum;        // One extra bit for the add
    synth_pkg::sample_t             total_sample;
    synth_pkg::sample_t             pwm_count;

    // ========================================================================
    // Delay line
    // ========================================================================
    // Read before write gives the sample from delay_depth cycles back
    assign delayed_sample = delay_ram[delay_ptr];

    always_ff @(posedge clk) begin
        delay_ram[delay_ptr] <= mix_sample;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            delay_ptr <= '0;
        else
            delay_ptr <= delay_ptr + 1'b1;
    end

    // Even blend of dry and delayed
    assign echo_sum     = {1'b0, mix_sample} + {1'b0, delayed_sample};
    assign total_sample = echo_on ? echo_sum[synth_pkg::pwm_bits:1] : mix_sample;

    // ========================================================================
    // PWM
    // ========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_count <= '0;
            audio_out <= 1'b0;
        end else begin
            pwm_count <= pwm_count + 1'b1;              // 1024 cycle frame
            audio_out <= (pwm_count < total_sample);    // Duty tracks sample
        end
    end

    silent_when_zero: assert property (@(posedge clk) disable iff (reset)
        total_sample == '0 |=> !audio_out);

endmodule

//--- hw/voice_mixer.sv
// Sine voice mixer
module voice_mixer #(
    parameter int num_voices = 8
) (
    voice_ctrl_if.voices voices,
    input  logic [num_voices-1:0][synth_pkg::lut_addr_bits-1:0] voice_addr,
    output synth_pkg::sample_t mix_sample
);
    localparam int lut_size = 1 << synth_pkg::lut_addr_bits;
    localparam int sum_bits = synth_pkg::pwm_bits + $clog2(num_voices + 1);  // No overflow
    localparam synth_pkg::sample_t sample_max = '1;

    typedef synth_pkg::sample_t rom_t [lut_size];

    // Table built at elaboration
    function automatic rom_t build_rom();
        rom_t rom;
        for (int a = 0; a < lut_size; a++)
            rom[a] = synth_pkg::sine_sample(a);
        return rom;
    endfunction

    localparam rom_t sine_rom = build_rom();

    logic [sum_bits-1:0] sine_sum;
    logic [sum_bits-1:0] scaled;   // Sum over 4

    // ========================================================================
    // Sum of active voices
    // ========================================================================
    always_comb begin
        sine_sum = '0;
        for (int v = 0; v < num_voices; v++) begin
            if (voices.voice_active[v])
                sine_sum += sum_bits'(sine_rom[voice_addr[v]]);
        end
    end

    assign scaled = sine_sum >> 2;

    // Silent when idle, clipped at full scale
    assign mix_sample = !(|voices.voice_active)          ? '0 :
                        (scaled > sum_bits'(sample_max)) ? sample_max :
                                                           scaled[synth_pkg::pwm_bits-1:0];

endmodule

//--- hw/dds_voice_bank.sv
// DDS oscillator bank
module dds_voice_bank #(
    parameter int num_voices = 8
) (
    input  logic          clk,
    input  logic          reset,
    voice_ctrl_if.voices  voices,
    output logic [num_voices-1:0][synth_pkg::lut_addr_bits-1:0] voice_addr
);
    localparam int pw = synth_pkg::phase_width;

    // ========================================================================
    // One oscillator per voice
    // ========================================================================
    for (genvar k = 0; k < num_voices; k++) begin : g_voice
        synth_pkg::freq_t   base_f;     // Table frequency of the held key
        logic [2:0]         shamt;      // Octave shift magnitude
        logic [31:0]        shifted_f;
        int                 final_s;    // Signed after pitch offset
        logic [31:0]        final_f;
        synth_pkg::phase_t  phase_inc;
        synth_pkg::phase_t  phase_acc;

        assign base_f = synth_pkg::note_freq(voices.voice_key[k]);

        // Negative shift divides, positive multiplies
        assign shamt = voices.octave_shift[2] ? -voices.octave_shift
                                              : voices.octave_shift;
        assign shifted_f = voices.octave_shift[2] ? (32'(base_f) >> shamt)
                                                  : (32'(base_f) << shamt);

        assign final_s = int'(shifted_f) + int'(voices.pitch_mod);
        assign final_f = (final_s < 0) ? '0 : 32'(final_s);  // Clamp below zero

        // Hz to phase step
        assign phase_inc = final_f * synth_pkg::phase_inc_mult;

        always_ff @(posedge clk or posedge reset) begin
            if (reset)
                phase_acc <= '0;
            else if (voices.voice_active[k])
                phase_acc <= phase_acc + phase_inc;  // Idle voice holds its phase
        end

        // Top bits index the sine ROM
        assign voice_addr[k] = phase_acc[pw-1 -: synth_pkg::lut_addr_bits];

        // Decoder must only allocate note keys
        key_has_freq: assert property (@(posedge clk) disable iff (reset)
            voices.voice_active[k] |-> base_f != '0);
    end

endmodule

//--- hw/key_event_decoder.sv
// Keyboard event decoder
module key_event_decoder #(
    parameter int num_voices = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  synth_pkg::key_code_t rx_data,
    input  logic                 rx_valid,   // One cycle per byte
    voice_ctrl_if.ctrl           ctrl,
    output logic                 echo_on
);
    localparam int idx_bits = (num_voices > 1) ? $clog2(num_voices) : 1;

    synth_pkg::key_code_t [num_voices-1:0] key_q;  // Code held by each voice
    logic [num_voices-1:0] active_q;
    synth_pkg::octave_t    octave_q;
    synth_pkg::pitch_t     pitch_q;
    logic                  break_pending;  // F0 seen, next byte is a release
    logic                  echo_q;

    logic [num_voices-1:0] key_hit;        // Active voices holding rx_data
    logic                  free_found;
    logic [idx_bits-1:0]   free_idx;       // Lowest idle voice
    logic                  alloc;          // New note gets a voice this cycle
    logic                  dup_active;

    // ========================================================================
    // Voice search
    // ========================================================================
    always_comb begin
        key_hit = '0;
        free_found = 1'b0;
        free_idx = '0;
        for (int i = 0; i < num_voices; i++) begin
            key_hit[i] = active_q[i] && (key_q[i] == rx_data);
            if (!active_q[i] && !free_found) begin
                free_found = 1'b1;
                free_idx = idx_bits'(i);
            end
        end
    end

    // Control codes and F0 have no frequency so never allocate
    assign alloc = rx_valid && !break_pending && free_found && !(|key_hit)
                   && (synth_pkg::note_freq(rx_data) != '0);

    // ========================================================================
    // Event handling
    // ========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q      <= '0;
            octave_q      <= '0;
            pitch_q       <= '0;
            break_pending <= 1'b0;
            echo_q        <= 1'b0;
        end else if (rx_valid) begin
            if (rx_data == synth_pkg::break_prefix) begin
                break_pending <= 1'b1;
            end else if (break_pending) begin
                break_pending <= 1'b0;
                active_q      <= active_q & ~key_hit;  // Release matching voices
            end else begin
                case (rx_data)
                    synth_pkg::key_oct_down: begin
                        if (octave_q > synth_pkg::min_octave)
                            octave_q <= octave_q - 3'sd1;
                    end
                    synth_pkg::key_oct_up: begin
                        if (octave_q < synth_pkg::max_octave)
                            octave_q <= octave_q + 3'sd1;
                    end
                    synth_pkg::key_pitch_down: begin
                        if (pitch_q > -synth_pkg::max_pitch_mod)
                            pitch_q <= pitch_q - synth_pkg::pitch_t'(synth_pkg::pitch_mod_step);
                    end
                    synth_pkg::key_pitch_up: begin
                        if (pitch_q < synth_pkg::max_pitch_mod)
                            pitch_q <= pitch_q + synth_pkg::pitch_t'(synth_pkg::pitch_mod_step);
                    end
                    synth_pkg::key_echo: echo_q <= ~echo_q;
                    default: begin
                        if (alloc)
                            active_q[free_idx] <= 1'b1;  // Full bank drops the note
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            key_q[free_idx] <= rx_data;
    end

    assign ctrl.voice_key    = key_q;
    assign ctrl.voice_active = active_q;
    assign ctrl.octave_shift = octave_q;
    assign ctrl.pitch_mod    = pitch_q;
    assign echo_on           = echo_q;

    // Same key sounding twice means the hit search missed
    always_comb begin
        dup_active = 1'b0;
        for (int i = 0; i < num_voices; i++) begin
            for (int j = i + 1; j < num_voices; j++) begin
                if (active_q[i] && active_q[j] && key_q[i] == key_q[j])
                    dup_active = 1'b1;
            end
        end
    end

    octave_in_range: assert property (@(posedge clk) disable iff (reset)
        octave_q >= synth_pkg::min_octave && octave_q <= synth_pkg::max_octave);
    pitch_in_range: assert property (@(posedge clk) disable iff (reset)
        pitch_q >= -synth_pkg::max_pitch_mod && pitch_q <= synth_pkg::max_pitch_mod);
    no_dup_voice: assert property (@(posedge clk) disable iff (reset) !dup_active);

endmodule

//--- hw/voice_ctrl_if.sv
// Voice control interface
interface voice_ctrl_if #(
    parameter int num_voices = 8
);
    synth_pkg::key_code_t [num_voices-1:0] voice_key;  // Scan code held per voice
    logic [num_voices-1:0]                 voice_active;
    synth_pkg::octave_t                    octave_shift;
    synth_pkg::pitch_t                     pitch_mod;     // Signed Hz offset

    // Decoder side
    modport ctrl (
        output voice_key, voice_active, octave_shift, pitch_mod
    );

    // Oscillator and mixer side
    modport voices (
        input voice_key, voice_active, octave_shift, pitch_mod
    );
endinterface

//--- hw/synth_pkg.sv
// Synth shared definitions
package synth_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int phase_width = 32;              // DDS accumulator width
    localparam int pwm_bits = 10;                 // Sample and PWM counter width
    localparam int lut_addr_bits = 8;             // Top phase bits into sine table
    localparam int unsigned phase_inc_mult = 42;  // Phase step per Hz at 100 MHz

    typedef logic [7:0]             key_code_t;   // PS/2 scan code
    typedef logic [11:0]            freq_t;       // Note frequency in Hz
    typedef logic signed [2:0]      octave_t;
    typedef logic signed [7:0]      pitch_t;      // Offset in Hz
    typedef logic [phase_width-1:0] phase_t;
    typedef logic [pwm_bits-1:0]    sample_t;

    // ========================================================================
    // Scan codes and limits
    // ========================================================================
    localparam key_code_t break_prefix   = 8'hf0;
    localparam key_code_t key_oct_down   = 8'h1a;  // Z
    localparam key_code_t key_oct_up     = 8'h22;  // X
    localparam key_code_t key_echo       = 8'h21;  // C
    localparam key_code_t key_pitch_down = 8'h2a;  // V
    localparam key_code_t key_pitch_up   = 8'h32;  // B

    localparam int max_octave = 3;
    localparam int min_octave = -3;
    localparam int max_pitch_mod = 100;
    localparam int pitch_mod_step = 4;

    // Piano row of the keyboard, one chromatic octave from C4
    function automatic freq_t note_freq(key_code_t code);
        case (code)
            8'h1c: return 12'd262;  // A  C4
            8'h1d: return 12'd277;  // W
            8'h1b: return 12'd294;  // S
            8'h24: return 12'd311;  // E
            8'h23: return 12'd330;  // D
            8'h2b: return 12'd349;  // F
            8'h2c: return 12'd370;  // T
            8'h34: return 12'd392;  // G
            8'h35: return 12'd415;  // Y
            8'h33: return 12'd440;  // H  A4
            8'h3c: return 12'd466;  // U
            8'h3b: return 12'd494;  // J
            8'h42: return 12'd523;  // K  C5
            default: return '0;     // Not a note
        endcase
    endfunction

    // Offset sine, full scale 0 to 1023
    function automatic sample_t sine_sample(int index);
        real angle;
        real value;
        angle = 2.0 * 3.14159265358979 * index / real'(1 << lut_addr_bits);
        value = 511.5 * (1.0 + $sin(angle));
        return sample_t'($rtoi(value + 0.5));  // Round to nearest
    endfunction

endpackage
